// ==== kd_tree_vectors.txt ====
# W addr dim median | P c4 c3 c2 c1 c0 leaf | D max_ack_delay   (all hex except D)
# Levels split on dims 0,1,2,3,4,0 with medians 400,200,600,100,7fe,400
W 00 0 400
W 01 1 200
W 02 1 200
W 03 2 600
W 04 2 600
W 05 2 600
W 06 2 600
W 07 3 100
W 08 3 100
W 09 3 100
W 0a 3 100
W 0b 3 100
W 0c 3 100
W 0d 3 100
W 0e 3 100
W 0f 4 7fe
W 10 4 7fe
W 11 4 7fe
W 12 4 7fe
W 13 4 7fe
W 14 4 7fe
W 15 4 7fe
W 16 4 7fe
W 17 4 7fe
W 18 4 7fe
W 19 4 7fe
W 1a 4 7fe
W 1b 4 7fe
W 1c 4 7fe
W 1d 4 7fe
W 1e 4 7fe
W 1f 0 400
W 20 0 400
W 21 0 400
W 22 0 400
W 23 0 400
W 24 0 400
W 25 0 400
W 26 0 400
W 27 0 400
W 28 0 400
W 29 0 400
W 2a 0 400
W 2b 0 400
W 2c 0 400
W 2d 0 400
W 2e 0 400
W 2f 0 400
W 30 0 400
W 31 0 400
W 32 0 400
W 33 0 400
W 34 0 400
W 35 0 400
W 36 0 400
W 37 0 400
W 38 0 400
W 39 0 400
W 3a 0 400
W 3b 0 400
W 3c 0 400
W 3d 0 400
W 3e 0 400
D 0
# Single patch, equal to every median on its path
P 7fe 100 600 200 400 00
# Streaming with immediate ack
P 7ff 101 601 201 401 3f
P 000 000 700 100 500 29
P 7ff 7ff 000 7ff 000 16
P 000 101 5ff 201 3ff 14
P 000 000 7ff 7ff 7ff 39
P 7ff 000 000 000 401 23
P 333 0ff 6aa 456 123 18
# Back-pressure
D 8
P 7fe 100 600 200 400 00
P 7ff 101 601 201 401 3f
P 000 000 700 100 500 29
P 7ff 7ff 000 7ff 000 16
P 000 101 5ff 201 3ff 14
P 000 000 7ff 7ff 7ff 39
P 7ff 000 000 000 401 23
P 333 0ff 6aa 456 123 18
# Reprogram root to dim 4 and leftmost leaf parent to dim 1
W 00 4 000
W 1f 1 1ff
P 000 100 600 200 400 01
P 000 000 700 100 500 09
P 7ff 101 601 201 401 3f
P 000 000 7ff 7ff 7ff 19

// ==== flist.f ====
kd_geom_pkg.sv
kd_bus_pkg.sv
kd_patch_intake.sv
kd_tree_level.sv
kd_leaf_emitter.sv
kd_tree_top.sv
kd_tree_assert.sv
kd_tree_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the KD-tree classifier testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module kd_tree_tb \
    -f flist.f \
    -o kd_tree_sim

./obj_dir/kd_tree_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
    exit 1
fi
exit 0

// ==== kd_tree_tb.sv ====
// Testbench for kd_tree_top that replays kd_tree_vectors.txt over both handshakes and the node port
`timescale 1ns/1ps

module kd_tree_tb;

    logic                     clk;
    logic                     rst_n;
    logic                     in_req;
    logic                     in_ack;
    kd_geom_pkg::patch_t      in_patch;
    logic                     out_req;
    logic                     out_ack;
    kd_bus_pkg::leaf_result_t out_result;
    logic                     node_wr_en;
    kd_bus_pkg::node_wr_t     node_wr;

    kd_bus_pkg::leaf_result_t exp_q [$];   // Expected results in arrival order
    int                       acc_q [$];   // Acceptance edge of each patch
    int    cycle       = 0;
    int    max_delay   = 0;
    int    mismatches  = 0;
    int    other_errs  = 0;
    int    res_idx     = 0;
    int    limit_cycles = 0;
    logic  limit_set   = 1'b0;
    logic [31:0] rng   = 32'he31c_acf6;

    kd_tree_top kd_tree_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic write_node(input logic [31:0] addr, input logic [31:0] dim,
                              input logic [31:0] median);
        // Pipeline must be drained before touching the nodes
        while (exp_q.size() != 0 || in_ack || out_req) @(negedge clk);
        @(negedge clk);
        node_wr_en      = 1'b1;
        node_wr.addr    = addr[5:0];
        node_wr.rec.dim = dim[2:0];
        node_wr.rec.median = median[10:0];
        @(negedge clk);
        node_wr_en = 1'b0;
    endtask

    task automatic send_patch(input kd_geom_pkg::patch_t p, input kd_geom_pkg::leaf_t leaf);
        kd_bus_pkg::leaf_result_t r;
        r.leaf  = leaf;
        r.patch = p;
        exp_q.push_back(r);
        @(negedge clk);
        in_patch = p;
        in_req   = 1'b1;
        while (!in_ack) @(negedge clk);
        acc_q.push_back(cycle);   // Edge that accepted the patch
        in_req = 1'b0;
        while (in_ack) @(negedge clk);
    endtask

    task automatic run_line(input string line);
        byte         c;
        int          n;
        logic [31:0] a, b, m, c0, c1, c2, c3, c4, lf;
        c = line.getc(0);
        if (c == "W") begin
            n = $sscanf(line, "W %h %h %h", a, b, m);
            if (n != 3) begin
                other_errs++;
                $display("vector file has a node write line that could not be read: %s", line);
            end else if (a >= 32'(kd_geom_pkg::node_count)) begin
                other_errs++;
                $display("vector file writes node %0h, which lies outside the tree", a);
            end else begin
                write_node(a, b, m);
            end
        end else if (c == "P") begin
            n = $sscanf(line, "P %h %h %h %h %h %h", c4, c3, c2, c1, c0, lf);
            if (n == 6) begin
                send_patch({c4[10:0], c3[10:0], c2[10:0], c1[10:0], c0[10:0]}, lf[5:0]);
            end else begin
                other_errs++;
                $display("vector file has a patch line that could not be read: %s", line);
            end
        end else if (c == "D") begin
            n = $sscanf(line, "D %d", a);
            if (n == 1) begin
                max_delay = int'(a);
            end else begin
                other_errs++;
                $display("vector file has a delay line that could not be read: %s", line);
            end
        end else if (c != "#" && c != "\n" && c != " " && c != 0) begin
            other_errs++;
            $display("vector file has a line that is not a known command: %s", line);
        end
    endtask

    // Sink side of the output port with random ack delay
    initial begin : sink
        int                       d;
        int                       acc;
        kd_bus_pkg::leaf_result_t exp;
        wait (rst_n);
        forever begin
            @(negedge clk);
            if (out_req && !out_ack) begin
                if (exp_q.size() == 0 || acc_q.size() == 0) begin
                    other_errs++;
                    $display("result arrived while no patch was outstanding");
                end else begin
                    exp = exp_q.pop_front();
                    acc = acc_q.pop_front();
                    check("out_result.leaf", 64'(out_result.leaf), 64'(exp.leaf));
                    check("out_result.patch", 64'(out_result.patch), 64'(exp.patch));
                    if (res_idx == 0) check("latency", 64'(cycle - acc), 64'd7);
                    res_idx++;
                end
                rng = xorshift(rng);
                d = int'(rng % 32'(max_delay + 1));
                repeat (d) @(negedge clk);
                out_ack = 1'b1;
                while (out_req) @(negedge clk);
                out_ack = 1'b0;
            end
        end
    end

    initial begin : watchdog
        wait (limit_set);
        repeat (limit_cycles) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", limit_cycles);
        $display("Result: FAILED");
        $finish;
    end

    initial begin : main
        int    fd;
        int    p_cnt;
        int    w_cnt;
        int    d_max;
        int    v;
        string line;
        string lines [$];
        rst_n      = 1'b0;
        in_req     = 1'b0;
        in_patch   = '0;
        out_ack    = 1'b0;
        node_wr_en = 1'b0;
        node_wr    = '0;
        p_cnt = 0;
        w_cnt = 0;
        d_max = 0;
        fd = $fopen("kd_tree_vectors.txt", "r");
        if (fd == 0) begin
            other_errs++;
            $display("could not open kd_tree_vectors.txt");
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) > 0) lines.push_back(line);
            end
            $fclose(fd);
        end
        foreach (lines[i]) begin
            if (lines[i].getc(0) == "P") p_cnt++;
            if (lines[i].getc(0) == "W") w_cnt++;
            if (lines[i].getc(0) == "D" && $sscanf(lines[i], "D %d", v) == 1 && v > d_max)
                d_max = v;
        end
        limit_cycles = p_cnt * (7 + d_max + 4) + 16 + w_cnt * 8 + 200;   // Generous margin
        limit_set = 1'b1;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        foreach (lines[i]) run_line(lines[i]);
        while (exp_q.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk);
        $display("errors: %0d mismatches, %0d other failures", mismatches, other_errs);
        if (mismatches == 0 && other_errs == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== kd_tree_assert.sv ====
// Protocol checks for kd_tree_top, attached to the DUT by bind from the testbench build
`timescale 1ns/1ps

module kd_tree_assert (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     in_req,
    input logic                     in_ack,
    input logic                     out_req,
    input logic                     out_ack,
    input kd_bus_pkg::leaf_result_t out_result,
    input logic                     node_wr_en,
    input kd_bus_pkg::node_wr_t     node_wr
);

    // Sink may drop ack only once req is gone
    in_ack_fall: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(in_ack) |-> !$past(in_req))
        else $error("in_ack fell while in_req was still high");

    out_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_req && !out_ack |=> out_req)
        else $error("out_req dropped before out_ack");

    out_data_stable: assert property (@(posedge clk) disable iff (!rst_n)
        out_req && $past(out_req) |-> $stable(out_result))
        else $error("out_result changed during a request");

    // Only five components exist
    node_dim_legal: assert property (@(posedge clk) disable iff (!rst_n)
        node_wr_en |-> node_wr.rec.dim < 3'd5)
        else $error("node write with split dimension above 4");

endmodule

bind kd_tree_top kd_tree_assert kd_tree_assert_i (.*);

// ==== kd_tree_top.sv ====
// Top level of the pipelined KD-tree classifier: intake, six level stages and the leaf emitter
`timescale 1ns/1ps

module kd_tree_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_req,
    output logic                     in_ack,
    input  kd_geom_pkg::patch_t      in_patch,
    output logic                     out_req,
    input  logic                     out_ack,
    output kd_bus_pkg::leaf_result_t out_result,
    input  logic                     node_wr_en,
    input  kd_bus_pkg::node_wr_t     node_wr
);

    // Stage k feeds level k, the last one feeds the emitter
    kd_bus_pkg::stage_t stage_chain [kd_geom_pkg::tree_depth+1];
    logic               advance;   // Global stall, low while the output buffer is busy

    kd_patch_intake kd_patch_intake_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_req    (in_req),
        .in_ack    (in_ack),
        .in_patch  (in_patch),
        .advance   (advance),
        .stage_out (stage_chain[0])
    );

    for (genvar lv = 0; lv < kd_geom_pkg::tree_depth; lv++) begin : gen_level
        kd_tree_level #(
            .level (lv)
        ) kd_tree_level_i (
            .clk        (clk),
            .rst_n      (rst_n),
            .advance    (advance),
            .node_wr_en (node_wr_en),
            .node_wr    (node_wr),
            .stage_in   (stage_chain[lv]),
            .stage_out  (stage_chain[lv+1])
        );
    end

    kd_leaf_emitter kd_leaf_emitter_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .stage_in   (stage_chain[kd_geom_pkg::tree_depth]),
        .advance    (advance),
        .out_req    (out_req),
        .out_ack    (out_ack),
        .out_result (out_result)
    );

endmodule

// ==== kd_leaf_emitter.sv ====
// Output side of the classifier: result buffer, four-phase output handshake and pipeline stall
`timescale 1ns/1ps

module kd_leaf_emitter (
    input  logic                     clk,
    input  logic                     rst_n,
    input  kd_bus_pkg::stage_t       stage_in,
    output logic                     advance,
    output logic                     out_req,
    input  logic                     out_ack,
    output kd_bus_pkg::leaf_result_t out_result
);

    typedef enum logic [1:0] {
        idle,
        requesting,
        wait_ack_low
    } emit_state_t;

    emit_state_t              state;
    logic                     load;
    kd_bus_pkg::leaf_result_t buf_q;

    // Buffer is free when idle, or once the sink has dropped ack
    assign advance = (state == idle) || ((state == wait_ack_low) && !out_ack);
    assign load    = advance && stage_in.valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (load) begin
                        state <= requesting;
                    end
                end
                requesting: begin
                    if (out_ack) begin
                        state <= wait_ack_low;   // Release buffer, drop req
                    end
                end
                wait_ack_low: begin
                    if (!out_ack) begin
                        state <= load ? requesting : idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // Result buffer, stable for the whole request
    always_ff @(posedge clk) begin
        if (load) begin
            buf_q.leaf  <= stage_in.path;   // Six choices made, path is the leaf
            buf_q.patch <= stage_in.patch;
        end
    end

    assign out_req    = (state == requesting);
    assign out_result = buf_q;

endmodule

// ==== kd_tree_level.sv ====
// One KD-tree level stage with its split records, the median compare and the stage register
`timescale 1ns/1ps

module kd_tree_level #(
    parameter int level = 0
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 advance,
    input  logic                 node_wr_en,
    input  kd_bus_pkg::node_wr_t node_wr,
    input  kd_bus_pkg::stage_t   stage_in,
    output kd_bus_pkg::stage_t   stage_out
);

    localparam int node_cnt  = 1 << level;
    localparam int node_base = node_cnt - 1;             // Heap address of position 0
    localparam int idx_width = (level > 0) ? level : 1;

    kd_bus_pkg::node_rec_t nodes [node_cnt];             // Split records loaded by the host
    logic                  wr_hit;
    logic [idx_width-1:0]  wr_idx;
    logic [idx_width-1:0]  rd_idx;
    kd_bus_pkg::node_rec_t rec;
    kd_geom_pkg::comp_t    comp_sel;
    logic                  go_right;
    kd_bus_pkg::stage_t    stage_q;

    // Claim only writes that fall inside this level's address window
    always_comb begin
        wr_hit = node_wr_en
              && (int'(node_wr.addr) >= node_base)
              && (int'(node_wr.addr) < node_base + node_cnt);
        wr_idx = idx_width'(int'(node_wr.addr) - node_base);
    end

    always_ff @(posedge clk) begin
        if (wr_hit) begin
            nodes[wr_idx] <= node_wr.rec;
        end
    end

    // Path so far is the position within this level
    assign rd_idx = stage_in.path[idx_width-1:0];
    assign rec    = nodes[rd_idx];

    // Pick the component named by the split dimension
    always_comb begin
        comp_sel = '0;
        for (int k = 0; k < kd_geom_pkg::comp_count; k++) begin
            if (rec.dim == kd_geom_pkg::dim_t'(k)) begin
                comp_sel = stage_in.patch[k*kd_geom_pkg::comp_width +: kd_geom_pkg::comp_width];
            end
        end
    end

    assign go_right = comp_sel > rec.median;   // Ties route left

    // Stage register holds while the emitter stalls
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stage_q.valid <= 1'b0;
        end else if (advance) begin
            stage_q.valid <= stage_in.valid;
            stage_q.patch <= stage_in.patch;
            stage_q.path  <= {stage_in.path[kd_geom_pkg::tree_depth-2:0], go_right};
        end
    end

    assign stage_out = stage_q;

endmodule

// ==== kd_patch_intake.sv ====
// Input side of the classifier: four-phase handshake that loads patches into the first stage
`timescale 1ns/1ps

module kd_patch_intake (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_req,
    output logic                in_ack,
    input  kd_geom_pkg::patch_t in_patch,
    input  logic                advance,
    output kd_bus_pkg::stage_t  stage_out
);

    logic               accept;
    kd_bus_pkg::stage_t stage_q;

    // New request seen and the pipeline is moving
    assign accept = in_req && !in_ack && advance;

    // Four-phase ack, rises on capture and falls once req is gone
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_ack <= 1'b0;
        end else if (accept) begin
            in_ack <= 1'b1;
        end else if (in_ack && !in_req) begin
            in_ack <= 1'b0;
        end
    end

    // First pipeline register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stage_q.valid <= 1'b0;
        end else if (advance) begin
            stage_q.valid <= accept;   // Bubble when nothing is taken
            if (accept) begin
                stage_q.patch <= in_patch;
                stage_q.path  <= '0;   // No choices made yet
            end
        end
    end

    assign stage_out = stage_q;

endmodule

// ==== kd_bus_pkg.sv ====
// Packed records passed between pipeline blocks and across the top-level ports
package kd_bus_pkg;

    // Split record held by one internal node (14 bits)
    typedef struct packed {
        kd_geom_pkg::dim_t  dim;      // Component the node splits on
        kd_geom_pkg::comp_t median;   // Greater goes right, equal goes left
    } node_rec_t;

    // Single-cycle node write from the host (20 bits)
    typedef struct packed {
        kd_geom_pkg::node_addr_t addr;
        node_rec_t               rec;
    } node_wr_t;

    // Contents of one pipeline stage register
    // Path grows by one bit per level, newest choice in the LSB
    typedef struct packed {
        logic                  valid;
        kd_geom_pkg::patch_t   patch;
        kd_geom_pkg::leaf_t    path;
    } stage_t;

    // Classification result handed to the output port (61 bits)
    typedef struct packed {
        kd_geom_pkg::leaf_t  leaf;
        kd_geom_pkg::patch_t patch;   // Echo of the classified patch
    } leaf_result_t;

endpackage

// ==== kd_geom_pkg.sv ====
// Tree geometry and data widths shared by the classifier RTL and its testbench
package kd_geom_pkg;

    localparam int tree_depth  = 6;                   // Internal levels, one per pipeline stage
    localparam int node_count  = (1 << tree_depth) - 1;
    localparam int comp_width  = 11;
    localparam int comp_count  = 5;
    localparam int patch_width = comp_width * comp_count;
    localparam int dim_width   = 3;                   // Enough for dims 0 to 4
    localparam int addr_width  = 6;                   // Heap address of an internal node

    // One patch component, also the width of a median
    typedef logic [comp_width-1:0] comp_t;

    // Split dimension, only 0 to comp_count-1 are legal
    typedef logic [dim_width-1:0] dim_t;

    // Level L, position p lives at 2^L - 1 + p
    typedef logic [addr_width-1:0] node_addr_t;

    // Leaf index, also the path of left/right choices, MSB taken first
    typedef logic [tree_depth-1:0] leaf_t;

    // Component k sits at bits comp_width*k and up
    typedef logic [patch_width-1:0] patch_t;

endpackage
